// File: mem_cfg_pkg.sv
// ----------------------------------------------------------------------
// Memory configuration package
// Word, strobe and bus address types plus default bank geometry
// ----------------------------------------------------------------------
`default_nettype none

package mem_cfg_pkg;

  // ----------------------------------------------------------------------
  // Data path types
  // ----------------------------------------------------------------------

  // One bus beat and one stored memory word
  typedef logic [31:0] data_t;

  // Byte strobes, one bit per byte of data_t
  typedef logic [3:0] strb_t;

  // AXI byte address as seen on AW and AR
  typedef logic [15:0] bus_addr_t;

  // ----------------------------------------------------------------------
  // Default geometry
  // ----------------------------------------------------------------------

  // Banks behind the slave port
  localparam int DEF_NUM_BANKS = 4;

  // Word address width of one bank, 512 words
  localparam int DEF_BANK_AW = 9;

endpackage : mem_cfg_pkg

`default_nettype wire

// File: axil_pkg.sv
// ----------------------------------------------------------------------
// AXI4-Lite package
// Response codes and the slave front-end FSM states
// ----------------------------------------------------------------------
`default_nettype none

package axil_pkg;

  // Response field of the B and R channels
  typedef logic [1:0] resp_t;

  // Normal completion
  localparam resp_t RESP_OKAY = 2'd0;
  // Address outside the populated range
  localparam resp_t RESP_SLVERR = 2'd2;

  // Front-end FSM
  // IDLE accepts a new write or read
  // WRESP holds bvalid until bready
  // RWAIT waits for the R handshake
  typedef enum logic [1:0] {
    IDLE,
    WRESP,
    RWAIT
  } front_state_t;

endpackage : axil_pkg

`default_nettype wire

// File: sdp_ram_bank.sv
// ----------------------------------------------------------------------
// Simple dual-port RAM bank
// Byte-strobed write port, registered read port with one-cycle latency
// ----------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module sdp_ram_bank
  import mem_cfg_pkg::*;
#(
  parameter int BANK_AW = DEF_BANK_AW
) (
  input  wire               clka,
  // Write port
  input  wire               wr_en,
  input  wire [BANK_AW-1:0] wr_addr,
  input  data_t             wr_data,
  input  strb_t             wr_strb,
  // Read port
  input  wire               rd_en,
  input  wire [BANK_AW-1:0] rd_addr,
  output data_t             rd_data
);

  // Number of bytes in one word
  localparam int NUM_BYTES = $bits(strb_t);

  // Storage array, contents undefined until written
  data_t mem [2**BANK_AW];

  // ----------------------------------------------------------------------
  // Write port
  // ----------------------------------------------------------------------

  // Only bytes with their strobe set are updated
  always_ff @(posedge clka) begin
    if (wr_en) begin
      for (int b = 0; b < NUM_BYTES; b++) begin
        if (wr_strb[b]) begin
          mem[wr_addr][8*b +: 8] <= wr_data[8*b +: 8];
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // Read port
  // ----------------------------------------------------------------------

  // Registered read, old data on a same-address write (read-first)
  // Output holds while rd_en is low
  always_ff @(posedge clka) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

  // ----------------------------------------------------------------------
  // Assertions
  // ----------------------------------------------------------------------

  // Enables are always driven to 0 or 1
  a_no_x_enables: assert property (@(posedge clka)
    !$isunknown({wr_en, rd_en}));

  // Addresses are known whenever their port is used
  a_no_x_wr_addr: assert property (@(posedge clka)
    wr_en |-> !$isunknown(wr_addr));
  a_no_x_rd_addr: assert property (@(posedge clka)
    rd_en |-> !$isunknown(rd_addr));

  // Read data does not move unless a read was issued
  a_rd_data_hold: assert property (@(posedge clka)
    !rd_en |=> $stable(rd_data));

endmodule : sdp_ram_bank

`default_nettype wire

// File: axil_mem_front.sv
// ----------------------------------------------------------------------
// AXI4-Lite memory front end
// Accepts AW/W and AR, decodes the bank map and issues bank requests
// ----------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module axil_mem_front
  import mem_cfg_pkg::*;
  import axil_pkg::*;
#(
  parameter int NUM_BANKS = DEF_NUM_BANKS,
  parameter int BANK_AW   = DEF_BANK_AW,
  // Width of a bank index, at least one bit
  parameter int BANK_SEL_W = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1
) (
  input  wire                  clka,
  input  wire                  rst,
  // Write address and data channels
  input  bus_addr_t            awaddr,
  input  wire                  awvalid,
  output logic                 awready,
  input  data_t                wdata,
  input  strb_t                wstrb,
  input  wire                  wvalid,
  output logic                 wready,
  // Write response channel
  output resp_t                bresp,
  output logic                 bvalid,
  input  wire                  bready,
  // Read address channel
  input  bus_addr_t            araddr,
  input  wire                  arvalid,
  output logic                 arready,
  // Bank write requests
  output logic [NUM_BANKS-1:0] wr_en,
  output logic [BANK_AW-1:0]   wr_addr,
  output data_t                wr_data,
  output strb_t                wr_strb,
  // Bank read requests
  output logic [NUM_BANKS-1:0] rd_en,
  output logic [BANK_AW-1:0]   rd_addr,
  // Read bookkeeping towards the R channel
  output logic                 rd_issue,
  output logic [BANK_SEL_W-1:0] rd_bank,
  output logic                 rd_err,
  input  wire                  rd_done
);

  // First byte address past the populated range
  localparam logic [16:0] ADDR_LIMIT = 17'(4 * NUM_BANKS * (2 ** BANK_AW));

  front_state_t state;

  // Handshakes at this edge
  logic wr_acc;
  logic rd_acc;

  // Decoded address fields
  logic                  aw_ok;
  logic                  ar_ok;
  logic [BANK_SEL_W-1:0] aw_bank;
  logic [BANK_SEL_W-1:0] ar_bank;

  // ----------------------------------------------------------------------
  // Address decode
  // ----------------------------------------------------------------------

  // Bank index sits above the word index and the byte offset
  function automatic logic [BANK_SEL_W-1:0] bank_of(input bus_addr_t addr);
    bus_addr_t upper;
    upper = addr >> (BANK_AW + 2);
    return upper[BANK_SEL_W-1:0];
  endfunction

  function automatic logic in_range(input bus_addr_t addr);
    return {1'b0, addr} < ADDR_LIMIT;
  endfunction

  assign aw_ok   = in_range(awaddr);
  assign ar_ok   = in_range(araddr);
  assign aw_bank = bank_of(awaddr);
  assign ar_bank = bank_of(araddr);

  // ----------------------------------------------------------------------
  // Channel handshakes
  // ----------------------------------------------------------------------

  // AW and W are taken together, writes win over reads
  assign awready = (state == IDLE) && awvalid && wvalid;
  assign wready  = awready;
  assign arready = (state == IDLE) && !awvalid && arvalid;
  assign bvalid  = (state == WRESP);

  assign wr_acc = awready;
  assign rd_acc = arready && arvalid;

  // ----------------------------------------------------------------------
  // Bank requests
  // ----------------------------------------------------------------------

  // Word index and payload are shared, enables are one-hot
  assign wr_addr = awaddr[BANK_AW+1:2];
  assign wr_data = wdata;
  assign wr_strb = wstrb;
  assign rd_addr = araddr[BANK_AW+1:2];

  always_comb begin
    for (int i = 0; i < NUM_BANKS; i++) begin
      wr_en[i] = wr_acc && aw_ok && (aw_bank == BANK_SEL_W'(i));
      rd_en[i] = rd_acc && ar_ok && (ar_bank == BANK_SEL_W'(i));
    end
  end

  // Read return needs the bank and the error flag
  assign rd_issue = rd_acc;
  assign rd_bank  = ar_bank;
  assign rd_err   = !ar_ok;

  // ----------------------------------------------------------------------
  // FSM
  // ----------------------------------------------------------------------

  always_ff @(posedge clka) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (wr_acc) begin
            state <= WRESP;
          end else if (rd_acc) begin
            state <= RWAIT;
          end
        end
        WRESP: begin
          if (bready) begin
            state <= IDLE;
          end
        end
        RWAIT: begin
          if (rd_done) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Response is fixed at the write handshake
  always_ff @(posedge clka) begin
    if (wr_acc) begin
      bresp <= aw_ok ? RESP_OKAY : RESP_SLVERR;
    end
  end

  // ----------------------------------------------------------------------
  // Assertions
  // ----------------------------------------------------------------------

  // B channel holds its response until taken
  a_bvalid_hold: assert property (@(posedge clka) disable iff (rst)
    bvalid && !bready |=> bvalid && $stable(bresp));

  // R completion only while a read is outstanding
  a_done_in_rwait: assert property (@(posedge clka) disable iff (rst)
    rd_done |-> state == RWAIT);

endmodule : axil_mem_front

`default_nettype wire

// File: read_return.sv
// ----------------------------------------------------------------------
// Read return path
// Steers the selected bank word into the held R channel register
// ----------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module read_return
  import mem_cfg_pkg::*;
  import axil_pkg::*;
#(
  parameter int NUM_BANKS  = DEF_NUM_BANKS,
  parameter int BANK_SEL_W = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1
) (
  input  wire                   clka,
  input  wire                   rst,
  // Read bookkeeping from the front end
  input  wire                   rd_issue,
  input  wire  [BANK_SEL_W-1:0] rd_bank,
  input  wire                   rd_err,
  // Registered bank outputs
  input  data_t                 bank_rdata [NUM_BANKS],
  // R channel
  input  wire                   rready,
  output data_t                 rdata,
  output resp_t                 rresp,
  output logic                  rvalid,
  output logic                  rd_done
);

  // Read issued one edge ago, bank data now valid
  logic                  issue_q;
  logic [BANK_SEL_W-1:0] bank_q;
  logic                  err_q;

  // ----------------------------------------------------------------------
  // Latency match with the RAM read register
  // ----------------------------------------------------------------------

  always_ff @(posedge clka) begin
    if (rst) begin
      issue_q <= 1'b0;
    end else begin
      issue_q <= rd_issue;
    end
  end

  always_ff @(posedge clka) begin
    if (rd_issue) begin
      bank_q <= rd_bank;
      err_q  <= rd_err;
    end
  end

  // ----------------------------------------------------------------------
  // R channel register
  // ----------------------------------------------------------------------

  always_ff @(posedge clka) begin
    if (rst) begin
      rvalid <= 1'b0;
    end else if (issue_q) begin
      rvalid <= 1'b1;
    end else if (rd_done) begin
      rvalid <= 1'b0;
    end
  end

  // Out of range returns zero with SLVERR
  always_ff @(posedge clka) begin
    if (issue_q) begin
      rdata <= err_q ? '0 : bank_rdata[bank_q];
      rresp <= err_q ? RESP_SLVERR : RESP_OKAY;
    end
  end

  assign rd_done = rvalid && rready;

  // ----------------------------------------------------------------------
  // Assertions
  // ----------------------------------------------------------------------

  // Payload and valid held under back-pressure
  a_r_hold: assert property (@(posedge clka) disable iff (rst)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

  // Only one read in flight
  a_single_read: assert property (@(posedge clka) disable iff (rst)
    rd_issue |-> !rvalid && !issue_q);

endmodule : read_return

`default_nettype wire

// File: banked_mem_top.sv
// ----------------------------------------------------------------------
// Banked memory top level
// AXI4-Lite slave front end, RAM bank array and read return path
// ----------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module banked_mem_top
  import mem_cfg_pkg::*;
  import axil_pkg::*;
#(
  parameter int NUM_BANKS = DEF_NUM_BANKS,
  parameter int BANK_AW   = DEF_BANK_AW
) (
  input  wire       clka,
  input  wire       rst,
  // AXI4-Lite slave
  input  bus_addr_t awaddr,
  input  wire       awvalid,
  output logic      awready,
  input  data_t     wdata,
  input  strb_t     wstrb,
  input  wire       wvalid,
  output logic      wready,
  output resp_t     bresp,
  output logic      bvalid,
  input  wire       bready,
  input  bus_addr_t araddr,
  input  wire       arvalid,
  output logic      arready,
  output data_t     rdata,
  output resp_t     rresp,
  output logic      rvalid,
  input  wire       rready
);

  localparam int BANK_SEL_W = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1;

  // Shared bank request bus
  logic [NUM_BANKS-1:0]  wr_en;
  logic [BANK_AW-1:0]    wr_addr;
  data_t                 wr_data;
  strb_t                 wr_strb;
  logic [NUM_BANKS-1:0]  rd_en;
  logic [BANK_AW-1:0]    rd_addr;

  // Read bookkeeping
  logic                  rd_issue;
  logic [BANK_SEL_W-1:0] rd_bank;
  logic                  rd_err;
  logic                  rd_done;

  // One registered word per bank
  data_t                 bank_rdata [NUM_BANKS];

  axil_mem_front #(
    .NUM_BANKS  (NUM_BANKS),
    .BANK_AW    (BANK_AW),
    .BANK_SEL_W (BANK_SEL_W)
  ) front_i (
    .clka     (clka),
    .rst      (rst),
    .awaddr   (awaddr),
    .awvalid  (awvalid),
    .awready  (awready),
    .wdata    (wdata),
    .wstrb    (wstrb),
    .wvalid   (wvalid),
    .wready   (wready),
    .bresp    (bresp),
    .bvalid   (bvalid),
    .bready   (bready),
    .araddr   (araddr),
    .arvalid  (arvalid),
    .arready  (arready),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .wr_strb  (wr_strb),
    .rd_en    (rd_en),
    .rd_addr  (rd_addr),
    .rd_issue (rd_issue),
    .rd_bank  (rd_bank),
    .rd_err   (rd_err),
    .rd_done  (rd_done)
  );

  // Bank array, each bank sees only its own enables
  for (genvar g = 0; g < NUM_BANKS; g++) begin : gen_bank
    sdp_ram_bank #(
      .BANK_AW (BANK_AW)
    ) bank_i (
      .clka    (clka),
      .wr_en   (wr_en[g]),
      .wr_addr (wr_addr),
      .wr_data (wr_data),
      .wr_strb (wr_strb),
      .rd_en   (rd_en[g]),
      .rd_addr (rd_addr),
      .rd_data (bank_rdata[g])
    );
  end

  read_return #(
    .NUM_BANKS  (NUM_BANKS),
    .BANK_SEL_W (BANK_SEL_W)
  ) rret_i (
    .clka       (clka),
    .rst        (rst),
    .rd_issue   (rd_issue),
    .rd_bank    (rd_bank),
    .rd_err     (rd_err),
    .bank_rdata (bank_rdata),
    .rready     (rready),
    .rdata      (rdata),
    .rresp      (rresp),
    .rvalid     (rvalid),
    .rd_done    (rd_done)
  );

endmodule : banked_mem_top

`default_nettype wire

// File: tb_banked_mem.sv
// ----------------------------------------------------------------------
// Banked memory testbench
// Runs AXI4-Lite transactions from a pattern file against a word model
// ----------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tb_banked_mem
  import mem_cfg_pkg::*;
  import axil_pkg::*;
();

  localparam int CLK_PERIOD  = 40;
  // Sample point inside the low clock phase
  localparam int QTR         = CLK_PERIOD / 4;
  localparam int ADDR_LIMIT  = 4 * DEF_NUM_BANKS * (2 ** DEF_BANK_AW);
  localparam int MODEL_WORDS = ADDR_LIMIT / 4;

  logic      clka;
  logic      rst;
  bus_addr_t awaddr;
  logic      awvalid;
  logic      awready;
  data_t     wdata;
  strb_t     wstrb;
  logic      wvalid;
  logic      wready;
  resp_t     bresp;
  logic      bvalid;
  logic      bready;
  bus_addr_t araddr;
  logic      arvalid;
  logic      arready;
  data_t     rdata;
  resp_t     rresp;
  logic      rvalid;
  logic      rready;

  // Pattern columns, one entry per transaction
  logic [7:0] q_op [$];
  bus_addr_t  q_addr [$];
  data_t      q_data [$];
  strb_t      q_strb [$];
  data_t      q_exp [$];
  resp_t      q_resp [$];

  // Reference word model over the whole populated range
  data_t       model [MODEL_WORDS];
  logic [15:0] lfsr_state = 16'd74;
  int          chk_cnt = 0;
  int          err_cnt = 0;

  banked_mem_top #(
    .NUM_BANKS (DEF_NUM_BANKS),
    .BANK_AW   (DEF_BANK_AW)
  ) dut_i (
    .clka    (clka),
    .rst     (rst),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready)
  );

  always #(CLK_PERIOD / 2) clka = ~clka;

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------

  // Fibonacci LFSR, taps 16 14 13 11, one new bit per call
  function automatic logic lfsr_step();
    logic fb;
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
  endfunction

  // Two LFSR bits give 0 to 3 stall cycles
  function automatic int ready_delay();
    logic b1;
    logic b0;
    b1 = lfsr_step();
    b0 = lfsr_step();
    return int'({b1, b0});
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    chk_cnt++;
    if (actual !== expected) begin
      err_cnt++;
      $display("FAILED %s expected %h actual %h", name, expected, actual);
    end
  endtask

  // Strobe rule, linear word index is addr[12:2]
  task automatic model_write(input bus_addr_t addr, input data_t data, input strb_t strb);
    int idx;
    idx = int'(addr) / 4;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        model[idx][8*b +: 8] = data[8*b +: 8];
      end
    end
  endtask

  task automatic load_patterns(output logic ok);
    int          fd;
    int          n;
    string       line;
    logic [7:0]  op;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] s;
    logic [31:0] e;
    logic [31:0] r;
    ok = 1'b0;
    fd = $fopen("banked_mem_patterns.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        // Comment and blank lines do not scan to six fields
        if (n > 0 && $sscanf(line, "%c %h %h %h %h %h", op, a, d, s, e, r) == 6 &&
            (op == "W" || op == "R")) begin
          q_op.push_back(op);
          q_addr.push_back(bus_addr_t'(a));
          q_data.push_back(data_t'(d));
          q_strb.push_back(strb_t'(s));
          q_exp.push_back(data_t'(e));
          q_resp.push_back(resp_t'(r));
        end
      end
      $fclose(fd);
      ok = (q_op.size() > 0);
    end
  endtask

  task automatic watchdog(input int n);
    longint limit;
    limit = longint'(n) * 12 * CLK_PERIOD + 2000;
    #(limit);
    $display("Timeout after %0d ns, the transactions did not complete, %0d errors so far",
             limit, err_cnt);
    $display("Checks failed");
    $finish;
  endtask

  // ----------------------------------------------------------------------
  // Bus transactions
  // ----------------------------------------------------------------------

  // AW and W together, then B with random bready stalls
  task automatic write_word(input bus_addr_t addr, input data_t data, input strb_t strb,
                            output resp_t resp);
    logic  taken;
    logic  done;
    int    dly;
    int    stalls;
    resp_t held;
    @(negedge clka);
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    taken   = 1'b0;
    while (!taken) begin
      #(QTR);
      taken = awready && wready;
      @(negedge clka);
    end
    awvalid = 1'b0;
    wvalid  = 1'b0;
    dly     = ready_delay();
    bready  = (dly == 0);
    #(QTR);
    check_value("bvalid after write handshake", 1, bvalid);
    held   = bresp;
    done   = 1'b0;
    stalls = 0;
    while (!done) begin
      done = bvalid && bready;
      if (!done) begin
        // Stalled B keeps its payload
        check_value("bvalid hold", 1, bvalid);
        check_value("bresp hold", held, bresp);
      end
      @(negedge clka);
      stalls++;
      bready = !done && (stalls >= dly);
      if (!done) begin
        #(QTR);
      end
    end
    resp = held;
  endtask

  // AR, fixed one-cycle RAM latency, then R with random rready stalls
  task automatic read_word(input bus_addr_t addr, output data_t data, output resp_t resp);
    logic  taken;
    logic  done;
    int    dly;
    int    stalls;
    data_t held_data;
    resp_t held_resp;
    @(negedge clka);
    araddr  = addr;
    arvalid = 1'b1;
    taken   = 1'b0;
    while (!taken) begin
      #(QTR);
      taken = arready && arvalid;
      @(negedge clka);
    end
    arvalid = 1'b0;
    dly     = ready_delay();
    #(QTR);
    check_value("rvalid early", 0, rvalid);
    @(negedge clka);
    rready = (dly == 0);
    #(QTR);
    check_value("rvalid latency", 1, rvalid);
    held_data = rdata;
    held_resp = rresp;
    done      = 1'b0;
    stalls    = 0;
    while (!done) begin
      done = rvalid && rready;
      if (!done) begin
        check_value("rvalid hold", 1, rvalid);
        check_value("rdata hold", held_data, rdata);
        check_value("rresp hold", held_resp, rresp);
      end
      @(negedge clka);
      stalls++;
      rready = !done && (stalls >= dly);
      if (!done) begin
        #(QTR);
      end
    end
    data = held_data;
    resp = held_resp;
  endtask

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------

  initial begin
    logic  ok;
    logic  in_rng;
    resp_t rule_resp;
    resp_t got_resp;
    data_t got_data;
    data_t model_val;
    string name;
    clka    = 1'b0;
    rst     = 1'b1;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    load_patterns(ok);
    if (!ok) begin
      $display("No transactions could be read from the pattern file");
      $display("Checks failed");
      $finish;
    end else begin
      fork
        watchdog(q_op.size());
      join_none
      repeat (2) @(negedge clka);
      rst = 1'b0;
      @(negedge clka);
      #(QTR);
      // Nothing ready or valid in the first cycle after reset
      check_value("reset awready", 0, awready);
      check_value("reset wready", 0, wready);
      check_value("reset bvalid", 0, bvalid);
      check_value("reset rvalid", 0, rvalid);
      check_value("reset arready", 0, arready);
      for (int i = 0; i < q_op.size(); i++) begin
        in_rng    = int'(q_addr[i]) < ADDR_LIMIT;
        rule_resp = in_rng ? RESP_OKAY : RESP_SLVERR;
        name      = $sformatf("%s %h", (q_op[i] == "W") ? "write" : "read", q_addr[i]);
        // File values must agree with the address map and the model
        check_value({name, " file resp"}, rule_resp, q_resp[i]);
        if (q_op[i] == "W") begin
          write_word(q_addr[i], q_data[i], q_strb[i], got_resp);
          check_value({name, " bresp"}, q_resp[i], got_resp);
          if (in_rng) begin
            model_write(q_addr[i], q_data[i], q_strb[i]);
          end
        end else begin
          model_val = in_rng ? model[int'(q_addr[i]) / 4] : '0;
          check_value({name, " file data"}, model_val, q_exp[i]);
          read_word(q_addr[i], got_data, got_resp);
          check_value({name, " rdata"}, q_exp[i], got_data);
          check_value({name, " rresp"}, q_resp[i], got_resp);
        end
      end
      $display("Run complete: %0d transactions, %0d checks, %0d errors",
               q_op.size(), chk_cnt, err_cnt);
      if (err_cnt == 0) begin
        $display("All checks passed");
      end else begin
        $display("Checks failed");
      end
      $finish;
    end
  end

endmodule : tb_banked_mem

`default_nettype wire

// File: banked_mem_patterns.txt
# op addr data strobe expected_data expected_resp, all fields hex
# data and strobe are unused on reads, expected data is unused on writes
W 0000 11111111 F 00000000 0
W 07FC 22222222 F 00000000 0
W 0800 33333333 F 00000000 0
W 0FFC 44444444 F 00000000 0
W 1000 55555555 F 00000000 0
W 17FC 66666666 F 00000000 0
W 1800 77777777 F 00000000 0
W 1FFC 88888888 F 00000000 0
R 0000 00000000 0 11111111 0
R 07FC 00000000 0 22222222 0
R 0800 00000000 0 33333333 0
R 0FFC 00000000 0 44444444 0
R 1000 00000000 0 55555555 0
R 17FC 00000000 0 66666666 0
R 1800 00000000 0 77777777 0
R 1FFC 00000000 0 88888888 0
W 0000 AABBCCDD 5 00000000 0
R 0000 00000000 0 11BB11DD 0
W 1FFC 5A000000 8 00000000 0
R 1FFC 00000000 0 5A888888 0
W 2000 DEADBEEF F 00000000 2
R 0000 00000000 0 11BB11DD 0
R 2000 00000000 0 00000000 2
W 0804 00000001 F 00000000 0
W 0804 00000002 F 00000000 0
W 0804 00000003 F 00000000 0
R 0804 00000000 0 00000003 0

// File: sources.f
mem_cfg_pkg.sv
axil_pkg.sv
sdp_ram_bank.sv
axil_mem_front.sv
read_return.sv
banked_mem_top.sv
tb_banked_mem.sv
